// ==== hdl/blit_defs.svh ====
/*
 * blitter register map and register field positions
 * register numbers are local to the blitter and 4 bits wide
 * a write to WORDS queues the blit, so write it last
 */
`ifndef BLIT_DEFS_SVH
`define BLIT_DEFS_SVH

`define BLIT_WORD_W             16      // data and vram word address width

// host register numbers
`define BLIT_REG_CTRL           4'h0
`define BLIT_REG_VAL_C          4'h1
`define BLIT_REG_MOD_S          4'h2
`define BLIT_REG_SRC_S          4'h3
`define BLIT_REG_MOD_D          4'h4
`define BLIT_REG_DST_D          4'h5
`define BLIT_REG_SHIFT          4'h6
`define BLIT_REG_LINES          4'h7
`define BLIT_REG_WORDS          4'h8

// CTRL fields
`define BLIT_CTRL_T_MSB         15      // transparency value T
`define BLIT_CTRL_T_LSB         8
`define BLIT_CTRL_T8            5       // 8-bit transparency
`define BLIT_CTRL_TRANSP        4       // transparency enable
`define BLIT_CTRL_C_AND         1       // AND with C instead of XOR
`define BLIT_CTRL_S_CONST       0       // constant source

// SHIFT fields
`define BLIT_SHIFT_FMASK_MSB    15      // first word nibble mask
`define BLIT_SHIFT_FMASK_LSB    12
`define BLIT_SHIFT_LMASK_MSB    11      // last word nibble mask
`define BLIT_SHIFT_LMASK_LSB    8
`define BLIT_SHIFT_AMT_MSB      1       // right shift in nibbles
`define BLIT_SHIFT_AMT_LSB      0

`endif

// ==== hdl/blit_pkg.sv ====
/*
 * shared types of the blitter
 * word and address width come from BLIT_WORD_W, the logic assumes 16
 * lines and words are stored as count minus one
 */
`include "blit_defs.svh"

package blit_pkg;

    typedef logic [`BLIT_WORD_W-1:0] word_t;        // vram data word
    typedef logic [`BLIT_WORD_W-1:0] addr_t;        // vram word address

    // bit n enables nibble n, bit 3 covers data[15:12]
    typedef logic [3:0] nib_mask_t;

    typedef struct packed {
        logic       s_const;                        // source is src_S itself, no reads
        logic       c_and;                          // D = S & C, else S ^ C
        logic       transp;                         // transparency enable
        logic       transp_8b;                      // compare bytes, else nibbles
        logic [7:0] transp_t;                       // transparency value T
    } blit_ctrl_t;

    // one complete blit, as queued by the host or as running
    typedef struct packed {
        blit_ctrl_t ctrl;
        logic [1:0] shift;                          // nibbles to shift right
        nib_mask_t  f_mask;                         // first word of each line
        nib_mask_t  l_mask;                         // last word of each line
        word_t      mod_s;                          // added to src at line end
        addr_t      src_s;                          // source address or constant
        word_t      val_c;
        word_t      mod_d;                          // added to dst at line end
        addr_t      dst_d;
        word_t      lines;                          // lines minus one
        word_t      words;                          // words per line minus one
    } blit_params_t;

    // source word, seen as nibbles for 4-bit and as bytes for 8-bit transparency
    typedef union packed {
        logic [3:0][3:0] nib;
        logic [1:0][7:0] oct;
    } src_word_u;

    typedef struct packed {
        logic      sel;                             // held with all fields until ack
        logic      wr;
        addr_t     addr;
        nib_mask_t mask;                            // write only
        word_t     data;                            // write only
    } vram_req_t;

    typedef enum logic [2:0] {
        IDLE,                                       // wait for a queued blit
        SETUP,                                      // take the queued setup
        LINE_BEG,                                   // load counters, start first access
        RD_S,                                       // source read
        WR_D,                                       // destination write
        LINE_END                                    // apply modulos, next line or finish
    } blit_state_t;

endpackage

// ==== hdl/blit_regs.sv ====
/*
 * host setup registers, one queued blit deep
 * no back-pressure: writes while full_o is high alter the queued blit
 * a WORDS write in the same cycle as take_i leaves the queue full
 */
`timescale 1ns/1ps
`include "blit_defs.svh"

module blit_regs import blit_pkg::*; (
    input  logic         clk,
    input  logic         reset_i,
    input  logic         reg_wr_i,          // single-cycle write strobe
    input  logic [3:0]   reg_num_i,
    input  word_t        reg_data_i,
    input  logic         take_i,            // sequencer copies the setup
    output blit_params_t params_o,
    output logic         full_o
);

    blit_params_t params_q;
    logic         full_q;

    assign params_o = params_q;
    assign full_o   = full_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            params_q <= '0;
            full_q   <= 1'b0;
        end else begin
            if (take_i) begin
                full_q <= 1'b0;             // setup now owned by sequencer
            end

            if (reg_wr_i) begin
                case (reg_num_i)
                    `BLIT_REG_CTRL: begin
                        params_q.ctrl.transp_t  <= reg_data_i[`BLIT_CTRL_T_MSB:`BLIT_CTRL_T_LSB];
                        params_q.ctrl.transp_8b <= reg_data_i[`BLIT_CTRL_T8];
                        params_q.ctrl.transp    <= reg_data_i[`BLIT_CTRL_TRANSP];
                        params_q.ctrl.c_and     <= reg_data_i[`BLIT_CTRL_C_AND];
                        params_q.ctrl.s_const   <= reg_data_i[`BLIT_CTRL_S_CONST];
                    end
                    `BLIT_REG_VAL_C: begin
                        params_q.val_c <= reg_data_i;
                    end
                    `BLIT_REG_MOD_S: begin
                        params_q.mod_s <= reg_data_i;
                    end
                    `BLIT_REG_SRC_S: begin
                        params_q.src_s <= reg_data_i;
                    end
                    `BLIT_REG_MOD_D: begin
                        params_q.mod_d <= reg_data_i;
                    end
                    `BLIT_REG_DST_D: begin
                        params_q.dst_d <= reg_data_i;
                    end
                    `BLIT_REG_SHIFT: begin
                        params_q.f_mask <=
                            reg_data_i[`BLIT_SHIFT_FMASK_MSB:`BLIT_SHIFT_FMASK_LSB];
                        params_q.l_mask <=
                            reg_data_i[`BLIT_SHIFT_LMASK_MSB:`BLIT_SHIFT_LMASK_LSB];
                        params_q.shift  <= reg_data_i[`BLIT_SHIFT_AMT_MSB:`BLIT_SHIFT_AMT_LSB];
                    end
                    `BLIT_REG_LINES: begin
                        params_q.lines <= reg_data_i;
                    end
                    `BLIT_REG_WORDS: begin
                        params_q.words <= reg_data_i;
                        full_q         <= 1'b1;     // queues the blit, wins over take
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// ==== hdl/blit_sequencer.sv ====
/*
 * blit state machine, counters and vram request control
 * one vram access in flight; all state holds while sel is high without ack
 * line counter underflow at bit 15 limits a blit to 32768 lines
 * busy_o rises with the take of a queued blit and falls on return to idle
 */
`timescale 1ns/1ps

module blit_sequencer import blit_pkg::*; (
    input  logic         clk,
    input  logic         reset_i,
    input  blit_params_t queued_params_i,
    input  logic         queue_full_i,
    output logic         take_o,
    output blit_params_t active_params_o,
    input  logic         vram_ack_i,
    output vram_req_t    req_o,             // sel, wr and addr only
    output logic         capture_o,
    output logic         setup_o,
    output logic         first_word_o,
    output logic         last_word_o,
    output logic         busy_o,
    output logic         done_intr_o
);

    blit_state_t           state_q, state_n;
    blit_params_t          params_q;
    logic                  sel_q, sel_n;
    logic                  wr_q, wr_n;
    addr_t                 addr_q, addr_n;
    addr_t                 src_q, src_n;
    addr_t                 dst_q, dst_n;
    word_t                 lines_q, lines_n;        // msb set on last line
    logic [$bits(word_t):0] count_q, count_n;       // extra msb set on last word
    logic                  first_q, first_n;
    logic                  busy_q, done_q, setup_q;
    logic                  advance, last_word, last_line;

    assign advance   = !sel_q || vram_ack_i;
    assign last_word = count_q[$bits(word_t)];
    assign last_line = lines_q[$bits(word_t)-1];

    assign req_o           = '{sel: sel_q, wr: wr_q, addr: addr_q, mask: '0, data: '0};
    assign active_params_o = params_q;
    assign capture_o       = (state_q == RD_S) && vram_ack_i;
    assign setup_o         = setup_q;       // params_q valid from here
    assign first_word_o    = first_q;
    assign last_word_o     = last_word;
    assign busy_o          = busy_q;
    assign done_intr_o     = done_q;

    always_comb begin
        state_n = state_q;
        sel_n   = 1'b0;
        wr_n    = 1'b0;
        addr_n  = addr_q;
        src_n   = src_q;
        dst_n   = dst_q;
        lines_n = lines_q;
        count_n = count_q;
        first_n = first_q;
        take_o  = 1'b0;

        case (state_q)
            IDLE: begin
                if (queue_full_i) begin
                    state_n = SETUP;
                end
            end
            SETUP: begin
                take_o  = 1'b1;
                src_n   = queued_params_i.src_s;
                dst_n   = queued_params_i.dst_d;
                lines_n = queued_params_i.lines;
                state_n = LINE_BEG;
            end
            LINE_BEG: begin
                first_n = 1'b1;
                lines_n = lines_q - 1'b1;                   // pre-decrement
                count_n = {1'b0, params_q.words} - 1'b1;
                sel_n   = 1'b1;
                if (!params_q.ctrl.s_const) begin
                    addr_n  = src_q;
                    state_n = RD_S;
                end else begin
                    wr_n    = 1'b1;
                    addr_n  = dst_q;
                    state_n = WR_D;
                end
            end
            RD_S: begin
                src_n   = addr_q + 1'b1;
                sel_n   = 1'b1;
                wr_n    = 1'b1;
                addr_n  = dst_q;
                state_n = WR_D;
            end
            WR_D: begin
                dst_n   = addr_q + 1'b1;
                addr_n  = addr_q + 1'b1;                    // next write in constant mode
                count_n = count_q - 1'b1;
                first_n = 1'b0;
                if (last_word) begin
                    state_n = LINE_END;
                end else if (!params_q.ctrl.s_const) begin
                    sel_n   = 1'b1;
                    addr_n  = src_q;
                    state_n = RD_S;
                end else begin
                    sel_n   = 1'b1;
                    wr_n    = 1'b1;
                    state_n = WR_D;
                end
            end
            LINE_END: begin
                src_n = src_q + params_q.mod_s;
                dst_n = dst_q + params_q.mod_d;
                if (!last_line) begin
                    state_n = LINE_BEG;
                end else if (queue_full_i) begin
                    state_n = SETUP;                        // chain without idling
                end else begin
                    state_n = IDLE;
                end
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            sel_q   <= 1'b0;
            wr_q    <= 1'b0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            setup_q <= 1'b0;
        end else begin
            if (advance) begin
                state_q <= state_n;
                sel_q   <= sel_n;
                wr_q    <= wr_n;
            end
            if (take_o) begin
                busy_q <= 1'b1;
            end else if (state_q == LINE_END && last_line && !queue_full_i) begin
                busy_q <= 1'b0;
            end
            done_q  <= (state_q == LINE_END) && last_line;
            setup_q <= take_o;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            addr_q  <= addr_n;
            src_q   <= src_n;
            dst_q   <= dst_n;
            lines_q <= lines_n;
            count_q <= count_n;
            first_q <= first_n;
        end
        if (take_o) begin
            params_q <= queued_params_i;
        end
    end

endmodule

// ==== hdl/blit_datapath.sv ====
/*
 * source word, nibble shifter, transparency and logic op
 * carried nibbles survive lines and blits, cleared only by reset
 * data_o and mask_o are combinational and only meaningful on writes
 */
`timescale 1ns/1ps

module blit_datapath import blit_pkg::*; (
    input  logic         clk,
    input  logic         reset_i,
    input  blit_params_t params_i,
    input  logic         setup_i,           // load src_S as constant source
    input  logic         capture_i,         // vram read data valid
    input  word_t        vram_data_i,
    input  logic         first_word_i,
    input  logic         last_word_i,
    output word_t        data_o,
    output nib_mask_t    mask_o
);

    src_word_u   val_s;
    logic [11:0] last_s;                    // low three nibbles of previous read
    nib_mask_t   result_t4, result_t8;
    nib_mask_t   f_mask, l_mask;
    blit_ctrl_t  ctrl;

    // previous low nibbles enter from the left
    function automatic word_t shift_nibbles(
        input logic [1:0]  amount,
        input word_t       cur,
        input logic [11:0] prev
    );
        case (amount)
            2'd0:    shift_nibbles = cur;
            2'd1:    shift_nibbles = {prev[3:0], cur[15:4]};
            2'd2:    shift_nibbles = {prev[7:0], cur[15:8]};
            default: shift_nibbles = {prev[11:0], cur[15:12]};
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            val_s  <= '0;
            last_s <= '0;
        end else if (capture_i) begin
            val_s  <= shift_nibbles(params_i.shift, vram_data_i, last_s);
            last_s <= vram_data_i[11:0];
        end else if (setup_i) begin
            val_s  <= params_i.src_s;
        end
    end

    assign ctrl = params_i.ctrl;

    // odd nibbles match T[7:4], even nibbles T[3:0]
    assign result_t4[3] = !ctrl.transp || (val_s.nib[3] != ctrl.transp_t[7:4]);
    assign result_t4[2] = !ctrl.transp || (val_s.nib[2] != ctrl.transp_t[3:0]);
    assign result_t4[1] = !ctrl.transp || (val_s.nib[1] != ctrl.transp_t[7:4]);
    assign result_t4[0] = !ctrl.transp || (val_s.nib[0] != ctrl.transp_t[3:0]);

    assign result_t8[3:2] = {2{!ctrl.transp || (val_s.oct[1] != ctrl.transp_t)}};
    assign result_t8[1:0] = {2{!ctrl.transp || (val_s.oct[0] != ctrl.transp_t)}};

    assign f_mask = first_word_i ? params_i.f_mask : 4'b1111;
    assign l_mask = last_word_i  ? params_i.l_mask : 4'b1111;

    assign mask_o = f_mask & l_mask & (ctrl.transp_8b ? result_t8 : result_t4);
    assign data_o = ctrl.c_and ? (val_s & params_i.val_c) : (val_s ^ params_i.val_c);

endmodule

// ==== hdl/blit_top.sv ====
/*
 * blitter top: register file, sequencer and data path
 * vram port uses a sel/ack handshake, request held until ack
 * read data must be valid in the ack cycle
 */
`timescale 1ns/1ps

module blit_top import blit_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       reg_wr_i,
    input  logic [3:0] reg_num_i,
    input  word_t      reg_data_i,
    output logic       busy_o,
    output logic       full_o,
    output logic       done_intr_o,
    output vram_req_t  vram_req_o,
    input  logic       vram_ack_i,
    input  word_t      vram_data_i
);

    blit_params_t queued_params, active_params;
    logic         queue_full, take;
    logic         setup, capture;
    logic         first_word, last_word;
    vram_req_t    seq_req;                  // sel, wr, addr
    word_t        dp_data;
    nib_mask_t    dp_mask;

    assign full_o     = queue_full;
    assign vram_req_o = '{sel: seq_req.sel, wr: seq_req.wr, addr: seq_req.addr,
                          mask: dp_mask, data: dp_data};

    blit_regs blit_regs_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .reg_wr_i   (reg_wr_i),
        .reg_num_i  (reg_num_i),
        .reg_data_i (reg_data_i),
        .take_i     (take),
        .params_o   (queued_params),
        .full_o     (queue_full)
    );

    blit_sequencer blit_sequencer_inst (
        .clk             (clk),
        .reset_i         (reset_i),
        .queued_params_i (queued_params),
        .queue_full_i    (queue_full),
        .take_o          (take),
        .active_params_o (active_params),
        .vram_ack_i      (vram_ack_i),
        .req_o           (seq_req),
        .capture_o       (capture),
        .setup_o         (setup),
        .first_word_o    (first_word),
        .last_word_o     (last_word),
        .busy_o          (busy_o),
        .done_intr_o     (done_intr_o)
    );

    blit_datapath blit_datapath_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .params_i     (active_params),
        .setup_i      (setup),
        .capture_i    (capture),
        .vram_data_i  (vram_data_i),
        .first_word_i (first_word),
        .last_word_i  (last_word),
        .data_o       (dp_data),
        .mask_o       (dp_mask)
    );

endmodule

// ==== bench/blit_sva.sv ====
/*
 * checks on the vram handshake and the status outputs of blit_top
 * bound into blit_top, ports match the top level port names
 */
`timescale 1ns/1ps

module blit_sva import blit_pkg::*; (
    input logic      clk,
    input logic      reset_i,
    input vram_req_t vram_req_o,
    input logic      vram_ack_i,
    input logic      busy_o,
    input logic      full_o,
    input logic      done_intr_o
);

    // every request field holds until the ack cycle
    property req_held;
        @(posedge clk) disable iff (reset_i)
            (vram_req_o.sel && !vram_ack_i) |=> (vram_req_o.sel && $stable(vram_req_o));
    endproperty

    property done_single;
        @(posedge clk) disable iff (reset_i)
            done_intr_o |=> !done_intr_o;
    endproperty

    property reset_clears;
        @(posedge clk)
            reset_i |=> (!busy_o && !full_o && !done_intr_o && !vram_req_o.sel && !vram_req_o.wr);
    endproperty

    assert property (req_held) else $error("vram request changed while waiting for ack");
    assert property (done_single) else $error("done_intr_o high for more than one cycle");
    assert property (reset_clears) else $error("status outputs not cleared by reset");

endmodule

// ==== bench/blit_tb.sv ====
/*
 * blit_top testbench with a 64K word vram model and random ack delays of 0 to 3
 * each table entry is one blit, a chained entry is queued while the one before runs
 * vram is compared in full against a reference model after every blit
 */
`timescale 1ns/1ps
`include "blit_defs.svh"

module blit_tb import blit_pkg::*; ();

    typedef struct packed {
        word_t ctrl, val_c, mod_s, src_s, mod_d, dst_d, shift, lines, words;
        logic  chained;
    } test_t;

    localparam int NUM_TESTS = 10;

    logic       clk, reset_i, reg_wr_i, vram_ack_i;
    logic [3:0] reg_num_i;
    word_t      reg_data_i, vram_data_i;
    logic       busy_o, full_o, done_intr_o;
    vram_req_t  vram_req_o;
    test_t      tests [NUM_TESTS];
    word_t      vram [65536];
    word_t      ref_mem [65536];
    logic [11:0] ref_prev;                  // low nibbles of the last modelled read
    int         errors, checks, reads, done_count, wait_cnt, limit;
    bit         pending, table_ready;

    blit_top blit_top_inst (.*);

    bind blit_top blit_sva blit_sva_inst (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(negedge clk) if (done_intr_o) done_count++;

    function automatic word_t fill_word(addr_t a);
        return {a[3:0], a[7:4], a[11:8], a[15:12]};     // nibble reversed address
    endfunction

    task automatic check_word(addr_t a, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch vram[%h]: got %h expected %h", a, got, exp);
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // vram slave, request served in the cycle ack is raised
    initial begin
        vram_ack_i  = 1'b0;
        vram_data_i = '0;
        void'($urandom(32'hfb91_85ab));
        for (int a = 0; a < 65536; a++) begin
            vram[a] = fill_word(addr_t'(a));
        end
        forever begin
            @(posedge clk);
            #1;
            vram_ack_i = 1'b0;
            if (vram_req_o.sel) begin
                if (!pending) begin
                    pending  = 1'b1;
                    wait_cnt = int'($urandom % 4);
                end
                if (wait_cnt == 0) begin
                    pending    = 1'b0;
                    vram_ack_i = 1'b1;
                    if (vram_req_o.wr) begin
                        for (int n = 0; n < 4; n++)
                            if (vram_req_o.mask[n])
                                vram[vram_req_o.addr][4*n +: 4] = vram_req_o.data[4*n +: 4];
                    end else begin
                        vram_data_i = vram[vram_req_o.addr];
                        reads++;
                    end
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    task automatic model_blit(test_t t);
        addr_t       src, dst;
        word_t       val, out;
        logic [31:0] pair;
        nib_mask_t   m;
        logic [7:0]  tv;
        src = t.src_s;
        dst = t.dst_d;
        val = t.src_s;
        tv  = t.ctrl[`BLIT_CTRL_T_MSB:`BLIT_CTRL_T_LSB];
        for (int l = 0; l <= int'(t.lines); l++) begin
            for (int w = 0; w <= int'(t.words); w++) begin
                if (!t.ctrl[`BLIT_CTRL_S_CONST]) begin
                    pair     = {4'h0, ref_prev, ref_mem[src]} >> (4 * int'(t.shift[1:0]));
                    ref_prev = ref_mem[src][11:0];
                    val      = pair[15:0];
                    src      = src + 16'd1;
                end
                m = 4'hf;
                if (w == 0) m = m & t.shift[`BLIT_SHIFT_FMASK_MSB:`BLIT_SHIFT_FMASK_LSB];
                if (w == int'(t.words))
                    m = m & t.shift[`BLIT_SHIFT_LMASK_MSB:`BLIT_SHIFT_LMASK_LSB];
                if (t.ctrl[`BLIT_CTRL_TRANSP] && t.ctrl[`BLIT_CTRL_T8]) begin
                    if (val[15:8] == tv) m[3:2] = 2'b00;
                    if (val[7:0] == tv) m[1:0] = 2'b00;
                end else if (t.ctrl[`BLIT_CTRL_TRANSP]) begin
                    for (int n = 0; n < 4; n++)
                        if (val[4*n +: 4] == ((n % 2 == 1) ? tv[7:4] : tv[3:0])) m[n] = 1'b0;
                end
                out = t.ctrl[`BLIT_CTRL_C_AND] ? (val & t.val_c) : (val ^ t.val_c);
                for (int n = 0; n < 4; n++)
                    if (m[n]) ref_mem[dst][4*n +: 4] = out[4*n +: 4];
                dst = dst + 16'd1;
            end
            src = src + t.mod_s;
            dst = dst + t.mod_d;
        end
    endtask

    function automatic int blit_words(test_t t);
        return (int'(t.lines) + 1) * (int'(t.words) + 1);
    endfunction

    task automatic write_reg(logic [3:0] num, word_t data);
        @(posedge clk);
        #1;
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        @(posedge clk);
        #1;
        reg_wr_i = 1'b0;
    endtask

    // WORDS goes last since it queues the blit
    task automatic start_blit(test_t t, inout int exp_reads);
        write_reg(`BLIT_REG_CTRL, t.ctrl);
        write_reg(`BLIT_REG_VAL_C, t.val_c);
        write_reg(`BLIT_REG_MOD_S, t.mod_s);
        write_reg(`BLIT_REG_SRC_S, t.src_s);
        write_reg(`BLIT_REG_MOD_D, t.mod_d);
        write_reg(`BLIT_REG_DST_D, t.dst_d);
        write_reg(`BLIT_REG_SHIFT, t.shift);
        write_reg(`BLIT_REG_LINES, t.lines);
        write_reg(`BLIT_REG_WORDS, t.words);
        @(negedge clk);
        check_flag("full_o", full_o, 1'b1);
        model_blit(t);
        if (!t.ctrl[`BLIT_CTRL_S_CONST]) exp_reads += blit_words(t);
    endtask

    task automatic wait_done();
        do @(negedge clk); while (!done_intr_o);
    endtask

    task automatic compare_memory();
        int bad;
        bad = 0;
        for (int a = 0; a < 65536 && bad < 8; a++) begin
            if (vram[a] !== ref_mem[a]) bad++;
            check_word(addr_t'(a), vram[a], ref_mem[a]);
        end
    endtask

    initial begin
        wait (table_ready);
        limit = 10;
        for (int i = 0; i < NUM_TESTS; i++) limit += blit_words(tests[i]) * 12 + 60;
        #(limit * 10);
        $display("timeout: blits did not finish within %0d cycles", limit);
        $display("Errors found");
        $finish;
    end

    initial begin
        int i, first, err0, done0, reads0, blits, exp_reads;
        reset_i    = 1'b1;
        reg_wr_i   = 1'b0;
        reg_num_i  = 4'h0;
        reg_data_i = '0;
        ref_prev   = '0;
        for (int a = 0; a < 65536; a++) begin
            ref_mem[a] = fill_word(addr_t'(a));
        end
        // ctrl, val_c, mod_s, src_s, mod_d, dst_d, shift, lines, words, chained
        tests[0] = '{16'h0000, 16'h0000, 16'd4, 16'h1000, 16'd8,
                     16'h8000, 16'hff00, 16'd3, 16'd5, 1'b0};
        tests[1] = '{16'h0001, 16'h00ff, 16'd0, 16'ha5a5, 16'd2,
                     16'h8100, 16'hff00, 16'd2, 16'd3, 1'b0};
        tests[2] = '{16'h0003, 16'h0ff0, 16'd0, 16'h1234, 16'd0,
                     16'h8200, 16'hff00, 16'd1, 16'd4, 1'b0};
        tests[3] = '{16'h0000, 16'h0000, 16'd1, 16'h1100, 16'd3,
                     16'h8300, 16'h7e01, 16'd2, 16'd4, 1'b0};
        tests[4] = '{16'h0000, 16'h0000, 16'd0, 16'h1200, 16'd2,
                     16'h8400, 16'h3c02, 16'd1, 16'd2, 1'b0};
        tests[5] = '{16'h0000, 16'h0000, 16'd2, 16'h1300, 16'd5,
                     16'h8500, 16'h9603, 16'd3, 16'd1, 1'b0};
        tests[6] = '{16'h2110, 16'h0000, 16'd0, 16'h1400, 16'd8,
                     16'h8600, 16'hff00, 16'd3, 16'd7, 1'b0};
        tests[7] = '{16'h3030, 16'h0000, 16'd0, 16'h1500, 16'd0,
                     16'h8700, 16'hff00, 16'd1, 16'd7, 1'b0};
        tests[8] = '{16'h0000, 16'h5555, 16'd0, 16'h2000, 16'd0,
                     16'h9000, 16'hff00, 16'd3, 16'd7, 1'b0};
        tests[9] = '{16'h0001, 16'h0000, 16'd0, 16'hbeef, 16'd1,
                     16'h9100, 16'hff00, 16'd2, 16'd3, 1'b1};
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset_i = 1'b0;
        i = 0;
        while (i < NUM_TESTS) begin
            first     = i;
            err0      = errors;
            done0     = done_count;
            reads0    = reads;
            exp_reads = 0;
            blits     = 1;
            start_blit(tests[i], exp_reads);
            if (i + 1 < NUM_TESTS && tests[i + 1].chained) begin
                do @(negedge clk); while (!busy_o);
                i++;
                blits = 2;
                start_blit(tests[i], exp_reads);
                wait_done();
                check_flag("busy_o at first done", busy_o, 1'b1);
                check_flag("full_o at first done", full_o, 1'b1);
                @(negedge clk);
                check_flag("busy_o after takeover", busy_o, 1'b1);
                check_flag("full_o after takeover", full_o, 1'b0);
            end
            wait_done();
            repeat (2) @(negedge clk);
            check_flag("busy_o after done", busy_o, 1'b0);
            check_addr("done pulses", addr_t'(done_count - done0), addr_t'(blits));
            check_addr("vram reads", addr_t'(reads - reads0), addr_t'(exp_reads));
            compare_memory();
            $display("test %0d..%0d: %s", first, i, (errors == err0) ? "passed" : "failed");
            i++;
        end
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/blit_pkg.sv
hdl/blit_regs.sv
hdl/blit_sequencer.sv
hdl/blit_datapath.sv
hdl/blit_top.sv
bench/blit_sva.sv
bench/blit_tb.sv

// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module blit_tb -f files.f -o blit_sim

run: build
	./obj_dir/blit_sim | tee sim.log
	grep -q "^No errors$$" sim.log

lint:
	verilator --lint-only --timing --assert --top-module blit_tb -f files.f

clean:
	rm -rf obj_dir sim.log
